// File: Bender.yml
package:
  name: cl_scrub

sources:
  - hw/cl_pkg.sv
  - hw/ddr_scrubber.sv
  - hw/cl_shell_ctl.sv
  - hw/ocl_slv.sv
  - hw/cl_scrub_top.sv

  - target: test
    files:
      - dv/ocl_slv_asserts.sv
      - dv/tb_cl_scrub_top.sv

vendor_package: []

// File: dv/ocl_slv_asserts.sv
// AXI4-Lite response checks bound into every ocl_slv instance
`timescale 1ns/1ps
`default_nettype none

module ocl_slv_asserts
   import cl_pkg::*;
(
   input logic              clk,
   input logic              sync_rst_n,
   input logic              awready,
   input logic              bvalid,
   input logic              bready,
   input logic [1:0]        bresp,
   input logic              rvalid,
   input logic              rready,
   input logic [DATA_W-1:0] rdata,
   input logic [1:0]        rresp
);

   // failed assertion count
   int unsigned fail_cnt = 0;

   // --------------------------------------------------
   // write response held under back-pressure
   // --------------------------------------------------
   a_b_stable : assert property (@(posedge clk) disable iff (!sync_rst_n)
      bvalid && !bready |=> bvalid && $stable(bresp))
      else
      begin
         $error("write response changed before bready");
         fail_cnt = fail_cnt + 1;
      end

   // read response
   a_r_stable : assert property (@(posedge clk) disable iff (!sync_rst_n)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
      else
      begin
         $error("read response changed before rready");
         fail_cnt = fail_cnt + 1;
      end

   // an accepted write answers on the next cycle
   a_aw_resp : assert property (@(posedge clk) disable iff (!sync_rst_n)
      awready |=> bvalid)
      else
      begin
         $error("accepted write gave no response on the next cycle");
         fail_cnt = fail_cnt + 1;
      end

endmodule

bind ocl_slv ocl_slv_asserts i_ocl_slv_asserts (.*);

`default_nettype wire

// File: dv/tb_cl_scrub_top.sv
// self-checking testbench driving cl_scrub_top with random stimulus against a cycle model
`timescale 1ns/1ps
`default_nettype none

module tb_cl_scrub_top
   import cl_pkg::*;
;

   localparam int                NUM_DDR        = 4;
   localparam int                NUM_CYCLES     = 4000;
   localparam int                RST_CYCLES     = 2;
   localparam int                TIMEOUT_CYCLES = 2 * (NUM_CYCLES + RST_CYCLES);
   localparam logic [ADDR_W-1:0] BURST_BYTES    = 64'(16 * LINE_BYTES);
   localparam logic [ADDR_W-1:0] LAST_ADDR      = 64'h1FFF + 64'd1 - BURST_BYTES;

   logic                clk = 1'b0;
   logic                sync_rst_n;
   logic [DATA_W-1:0]   ctl0;
   logic [NUM_DDR-1:0]  ddr_ready;
   logic                flr_assert;
   logic                flr_done;
   logic [DATA_W-1:0]   id0;
   logic [DATA_W-1:0]   id1;
   logic                awvalid;
   logic                awready;
   logic [31:0]         awaddr;
   logic                wvalid;
   logic                wready;
   logic [DATA_W-1:0]   wdata;
   logic [DATA_W/8-1:0] wstrb;
   logic                bvalid;
   logic                bready;
   logic [1:0]          bresp;
   logic                arvalid;
   logic                arready;
   logic [31:0]         araddr;
   logic                rvalid;
   logic                rready;
   logic [DATA_W-1:0]   rdata;
   logic [1:0]          rresp;

   // model state
   logic [DATA_W-1:0]   m_ctl0_q;
   logic [NUM_DDR-1:0]  m_ready_q;
   logic                m_flr_q;
   logic                m_flr_done;
   logic [DATA_W-1:0]   m_id0;
   logic [DATA_W-1:0]   m_id1;
   logic [ADDR_W-1:0]   m_addr [NUM_DDR];
   logic [NUM_DDR-1:0]  m_done;
   logic [DATA_W-1:0]   m_scratch;
   logic                m_bvalid;
   logic [1:0]          m_bresp;
   logic                m_rvalid;
   logic [DATA_W-1:0]   m_rdata;
   logic [1:0]          m_rresp;
   logic                wr_acc;
   logic                rd_acc;

   logic [31:0]         rng_state = 32'h9add;
   int                  flr_left  = 0;
   int unsigned         cycle_cnt = 0;

   cl_scrub_top i_cl_scrub_top (.*);

   always #20 clk = ~clk;

   // --------------------------------------------------
   // random numbers and checking
   // --------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [31:0] rand32();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // half the accesses go to scratch and the rest spread over 0x00..0x3c
   function automatic logic [31:0] pick_offset();
      logic [31:0] r;
      r = rand32();
      if (r[4])
         return REG_SCRATCH;
      return {26'd0, r[3:0], 2'b00};
   endfunction

   task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (act !== exp)
      begin
         $display("** Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
         $display("TEST FAILED");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   // --------------------------------------------------
   // reference model
   // --------------------------------------------------
   task automatic reg_read(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      logic [31:0] offs;
      int          ch;
      data = '0;
      resp = RESP_SLVERR;
      offs = addr - REG_ADDR_BASE;
      ch   = int'(offs >> 3);
      if (addr == REG_STATUS)
      begin
         data[NUM_DDR-1:0]   = m_done;
         data[NUM_DDR+3:4]   = m_ready_q;
         resp                = RESP_OKAY;
      end
      else if (addr == REG_SCRATCH)
      begin
         data = m_scratch;
         resp = RESP_OKAY;
      end
      else if (addr >= REG_ADDR_BASE && offs < 32'(8 * NUM_DDR) && addr[1:0] == 2'b00)
      begin
         data = offs[2] ? m_addr[ch][63:32] : m_addr[ch][31:0];
         resp = RESP_OKAY;
      end
   endtask

   // one clock edge with every next value taken from the pre-edge state
   task automatic model_step();
      logic [31:0]       rd_word;
      logic [1:0]        rd_code;
      logic [ADDR_W-1:0] sel_addr;
      int                sel;
      rd_acc = arvalid && !m_rvalid;
      reg_read(araddr, rd_word, rd_code);
      if (rd_acc)
      begin
         m_rvalid = 1'b1;
         m_rdata  = rd_word;
         m_rresp  = rd_code;
      end
      else if (rready)
         m_rvalid = 1'b0;
      sel = int'(m_ctl0_q[CTL_DBG_SEL_LSB +: 3]);
      if (sel >= NUM_DDR)
         sel = 0;
      sel_addr = m_addr[sel];
      m_id0    = m_ctl0_q[CTL_DBG_EN_BIT] ? sel_addr[31:0]  : CL_ID0;
      m_id1    = m_ctl0_q[CTL_DBG_EN_BIT] ? sel_addr[63:32] : CL_ID1;
      for (int i = 0; i < NUM_DDR; i++)
      begin
         if (!m_ctl0_q[i])
         begin
            m_addr[i] = '0;
            m_done[i] = 1'b0;
         end
         else if (m_ready_q[i] && !m_done[i])
         begin
            if (m_addr[i] == LAST_ADDR)
               m_done[i] = 1'b1;
            else
               m_addr[i] = m_addr[i] + BURST_BYTES;
         end
      end
      m_flr_done = m_flr_q && !m_flr_done;
      m_flr_q    = flr_assert;
      wr_acc     = awvalid && wvalid && !m_bvalid;
      if (wr_acc)
      begin
         m_bvalid = 1'b1;
         m_bresp  = (awaddr == REG_SCRATCH) ? RESP_OKAY : RESP_SLVERR;
         for (int b = 0; b < 4; b++)
         begin
            if (awaddr == REG_SCRATCH && wstrb[b])
               m_scratch[8*b +: 8] = wdata[8*b +: 8];
         end
      end
      else if (bready)
         m_bvalid = 1'b0;
      m_ctl0_q  = ctl0;
      m_ready_q = ddr_ready;
   endtask

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------
   task automatic drive_inputs();
      logic [31:0] r;
      logic [31:0] r2;
      r  = rand32();
      r2 = rand32();
      // control word changes rarely so scrubs can finish
      if (r[5:0] == 6'd0)
      begin
         ctl0              = r2;
         // enables biased high
         ctl0[NUM_DDR-1:0] = r2[NUM_DDR-1:0] | r[11:8];
      end
      ddr_ready = r2[19:16] | r2[23:20];
      if (flr_left == 0)
      begin
         flr_assert = r[12];
         flr_left   = int'(r[15:13]) + 1;
      end
      flr_left = flr_left - 1;
      bready   = |r[17:16];
      rready   = |r[19:18];
      // a request holds until it is taken
      if (!awvalid || wr_acc)
      begin
         awvalid = r[20];
         wvalid  = r[20];
         awaddr  = pick_offset();
         wdata   = rand32();
         wstrb   = r[27:24];
      end
      if (!arvalid || rd_acc)
      begin
         arvalid = r[21] | r[22];
         araddr  = pick_offset();
      end
   endtask

   task automatic check_outputs();
      check("flr_done", m_flr_done, flr_done);
      check("id0", m_id0, id0);
      check("id1", m_id1, id1);
      check("awready", awvalid && wvalid && !m_bvalid, awready);
      check("wready", awvalid && wvalid && !m_bvalid, wready);
      check("arready", arvalid && !m_rvalid, arready);
      check("bvalid", m_bvalid, bvalid);
      check("rvalid", m_rvalid, rvalid);
      if (m_bvalid)
         check("bresp", m_bresp, bresp);
      if (m_rvalid)
      begin
         check("rdata", m_rdata, rdata);
         check("rresp", m_rresp, rresp);
      end
      check("ocl assertion failures", 64'd0,
            64'(i_cl_scrub_top.i_ocl_slv.i_ocl_slv_asserts.fail_cnt));
   endtask

   // --------------------------------------------------
   // run
   // --------------------------------------------------
   initial
   begin
      sync_rst_n = 1'b0;
      ctl0       = '0;
      ddr_ready  = '0;
      flr_assert = 1'b0;
      awvalid    = 1'b0;
      awaddr     = '0;
      wvalid     = 1'b0;
      wdata      = '0;
      wstrb      = '0;
      bready     = 1'b0;
      arvalid    = 1'b0;
      araddr     = '0;
      rready     = 1'b0;
      m_ctl0_q   = '0;
      m_ready_q  = '0;
      m_flr_q    = 1'b0;
      m_flr_done = 1'b0;
      m_id0      = CL_ID0;
      m_id1      = CL_ID1;
      m_done     = '0;
      m_scratch  = '0;
      m_bvalid   = 1'b0;
      m_bresp    = RESP_OKAY;
      m_rvalid   = 1'b0;
      m_rdata    = '0;
      m_rresp    = RESP_OKAY;
      wr_acc     = 1'b0;
      rd_acc     = 1'b0;
      for (int i = 0; i < NUM_DDR; i++)
         m_addr[i] = '0;
      repeat (RST_CYCLES) @(posedge clk);
      #2 sync_rst_n = 1'b1;
      #1 check_outputs();
      for (int c = 0; c < NUM_CYCLES; c++)
      begin
         @(posedge clk);
         model_step();
         #2 drive_inputs();
         #1 check_outputs();
      end
      $display("TEST PASSED");
      $finish;
   end

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("timeout: run went past %0d clock cycles", TIMEOUT_CYCLES);
         $display("TEST FAILED");
         $fatal(1, "simulation timeout");
      end
   end

endmodule

`default_nettype wire

// File: files.f
hw/cl_pkg.sv
hw/ddr_scrubber.sv
hw/cl_shell_ctl.sv
hw/ocl_slv.sv
hw/cl_scrub_top.sv
dv/ocl_slv_asserts.sv
dv/tb_cl_scrub_top.sv

// File: hw/cl_pkg.sv
// shared widths, card IDs, control-word fields and OCL register map; import with cl_pkg::*
`default_nettype none

package cl_pkg;

   // --------------------------------------------------
   // widths
   // --------------------------------------------------
   localparam int ADDR_W     = 64;
   localparam int DATA_W     = 32;
   // one DDR beat is 512 bits
   localparam int LINE_BYTES = 64;

   // --------------------------------------------------
   // fixed card IDs
   // --------------------------------------------------
   // device id in the upper half, vendor id in the lower half
   localparam logic [DATA_W-1:0] CL_ID0 = 32'hF000_1D0F;
   // subsystem device and subsystem vendor
   localparam logic [DATA_W-1:0] CL_ID1 = 32'h1D51_FEDD;

   // control word fields, scrub enables sit in the low bits
   localparam int CTL_DBG_EN_BIT  = 31;
   localparam int CTL_DBG_SEL_LSB = 28;

   // --------------------------------------------------
   // OCL register map, byte offsets
   // --------------------------------------------------
   localparam logic [31:0] REG_STATUS    = 32'h0000_0000;
   localparam logic [31:0] REG_SCRATCH   = 32'h0000_0004;
   // channel i low word at base + 8i, high word at base + 8i + 4
   localparam logic [31:0] REG_ADDR_BASE = 32'h0000_0010;

   localparam logic [1:0] RESP_OKAY   = 2'd0;
   localparam logic [1:0] RESP_SLVERR = 2'd2;

endpackage

`default_nettype wire

// File: hw/cl_scrub_top.sv
// top of the scrub shell: control block, one scrubber per DDR channel and the OCL slave
`timescale 1ns/1ps
`default_nettype none

module cl_scrub_top
   import cl_pkg::*;
#(
   parameter int                NUM_DDR               = 4,
   parameter logic [ADDR_W-1:0] SCRB_MAX_ADDR         = 64'h1FFF,
   parameter int                SCRB_BURST_LEN_MINUS1 = 15
)
(
   input  logic                  clk,
   input  logic                  sync_rst_n,
   input  logic [DATA_W-1:0]     ctl0,
   input  logic [NUM_DDR-1:0]    ddr_ready,
   input  logic                  flr_assert,
   output logic                  flr_done,
   output logic [DATA_W-1:0]     id0,
   output logic [DATA_W-1:0]     id1,
   // OCL AXI4-Lite slave
   input  logic                  awvalid,
   output logic                  awready,
   input  logic [31:0]           awaddr,
   input  logic                  wvalid,
   output logic                  wready,
   input  logic [DATA_W-1:0]     wdata,
   input  logic [DATA_W/8-1:0]   wstrb,
   output logic                  bvalid,
   input  logic                  bready,
   output logic [1:0]            bresp,
   input  logic                  arvalid,
   output logic                  arready,
   input  logic [31:0]           araddr,
   output logic                  rvalid,
   input  logic                  rready,
   output logic [DATA_W-1:0]     rdata,
   output logic [1:0]            rresp
);

   logic [NUM_DDR-1:0] scrb_en;
   logic [NUM_DDR-1:0] ready_q;
   logic [NUM_DDR-1:0] scrb_done;
   logic [ADDR_W-1:0]  scrb_addr [NUM_DDR];

   cl_shell_ctl #(
      .NUM_DDR (NUM_DDR)
   ) i_cl_shell_ctl (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ctl0       (ctl0),
      .ddr_ready  (ddr_ready),
      .flr_assert (flr_assert),
      .scrb_addr  (scrb_addr),
      .scrb_en    (scrb_en),
      .ready_q    (ready_q),
      .flr_done   (flr_done),
      .id0        (id0),
      .id1        (id1)
   );

   // --------------------------------------------------
   // one scrubber per channel
   // --------------------------------------------------
   for (genvar g = 0; g < NUM_DDR; g++)
   begin : g_scrb
      ddr_scrubber #(
         .SCRB_MAX_ADDR         (SCRB_MAX_ADDR),
         .SCRB_BURST_LEN_MINUS1 (SCRB_BURST_LEN_MINUS1)
      ) i_ddr_scrubber (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .scrb_en    (scrb_en[g]),
         .ddr_ready  (ready_q[g]),
         .scrb_addr  (scrb_addr[g]),
         .scrb_done  (scrb_done[g])
      );
   end

   ocl_slv #(
      .NUM_DDR (NUM_DDR)
   ) i_ocl_slv (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ready_q    (ready_q),
      .scrb_done  (scrb_done),
      .scrb_addr  (scrb_addr),
      .awvalid    (awvalid),
      .awready    (awready),
      .awaddr     (awaddr),
      .wvalid     (wvalid),
      .wready     (wready),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .bvalid     (bvalid),
      .bready     (bready),
      .bresp      (bresp),
      .arvalid    (arvalid),
      .arready    (arready),
      .araddr     (araddr),
      .rvalid     (rvalid),
      .rready     (rready),
      .rdata      (rdata),
      .rresp      (rresp)
   );

endmodule

`default_nettype wire

// File: hw/cl_shell_ctl.sv
// control word and DDR ready sampling, FLR response and debug ID mux of the scrub shell
`timescale 1ns/1ps
`default_nettype none

module cl_shell_ctl
   import cl_pkg::*;
#(
   parameter int NUM_DDR = 4
)
(
   input  logic                clk,
   input  logic                sync_rst_n,
   input  logic [DATA_W-1:0]   ctl0,
   input  logic [NUM_DDR-1:0]  ddr_ready,
   input  logic                flr_assert,
   input  logic [ADDR_W-1:0]   scrb_addr [NUM_DDR],
   output logic [NUM_DDR-1:0]  scrb_en,
   output logic [NUM_DDR-1:0]  ready_q,
   output logic                flr_done,
   output logic [DATA_W-1:0]   id0,
   output logic [DATA_W-1:0]   id1
);

   logic [DATA_W-1:0] ctl0_q;
   logic              flr_assert_q;
   logic              dbg_en;
   logic [2:0]        dbg_sel;
   logic [ADDR_W-1:0] dbg_addr;

   // --------------------------------------------------
   // input sampling
   // --------------------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ctl0_q  <= '0;
         ready_q <= '0;
      end
      else
      begin
         ctl0_q  <= ctl0;
         ready_q <= ddr_ready;
      end
   end

   assign scrb_en = ctl0_q[NUM_DDR-1:0];
   assign dbg_en  = ctl0_q[CTL_DBG_EN_BIT];
   assign dbg_sel = ctl0_q[CTL_DBG_SEL_LSB +: 3];

   // --------------------------------------------------
   // FLR, done toggles while the request stays high
   // --------------------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_done     <= 1'b0;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         flr_done     <= flr_assert_q && !flr_done;
      end
   end

   // --------------------------------------------------
   // debug ID mux
   // --------------------------------------------------
   // a select past the last channel falls back to channel 0
   always_comb
   begin
      dbg_addr = scrb_addr[0];
      for (int i = 1; i < NUM_DDR; i++)
      begin
         if (dbg_sel == 3'(i))
            dbg_addr = scrb_addr[i];
      end
   end

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         id0 <= CL_ID0;
         id1 <= CL_ID1;
      end
      else
      begin
         id0 <= dbg_en ? dbg_addr[DATA_W-1:0]      : CL_ID0;
         id1 <= dbg_en ? dbg_addr[ADDR_W-1:DATA_W] : CL_ID1;
      end
   end

endmodule

`default_nettype wire

// File: hw/ddr_scrubber.sv
// per-channel scrub address walker, one burst per ready cycle, instantiated once per DDR
`timescale 1ns/1ps
`default_nettype none

module ddr_scrubber
   import cl_pkg::*;
#(
   parameter logic [ADDR_W-1:0] SCRB_MAX_ADDR         = 64'h1FFF,
   parameter int                SCRB_BURST_LEN_MINUS1 = 15
)
(
   input  logic              clk,
   input  logic              sync_rst_n,
   input  logic              scrb_en,
   input  logic              ddr_ready,
   output logic [ADDR_W-1:0] scrb_addr,
   output logic              scrb_done
);

   // bytes covered by one burst
   localparam logic [ADDR_W-1:0] BURST_BYTES =
      ADDR_W'((SCRB_BURST_LEN_MINUS1 + 1) * LINE_BYTES);

   // start address of the final burst
   localparam logic [ADDR_W-1:0] LAST_ADDR = SCRB_MAX_ADDR + 64'd1 - BURST_BYTES;

   logic step;
   logic at_last;

   // advance only while enabled, ready and not finished
   assign step    = scrb_en && ddr_ready && !scrb_done;
   assign at_last = (scrb_addr == LAST_ADDR);

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         scrb_addr <= '0;
         scrb_done <= 1'b0;
      end
      else if (!scrb_en)
      begin
         // disabled channel restarts from address 0
         scrb_addr <= '0;
         scrb_done <= 1'b0;
      end
      else if (step)
      begin
         if (at_last)
         begin
            // address holds on the last burst once done
            scrb_done <= 1'b1;
         end
         else
         begin
            scrb_addr <= scrb_addr + BURST_BYTES;
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/ocl_slv.sv
// AXI4-Lite register slave on the OCL port: status, scrub addresses and a scratch word
`timescale 1ns/1ps
`default_nettype none

module ocl_slv
   import cl_pkg::*;
#(
   parameter int NUM_DDR = 4
)
(
   input  logic                  clk,
   input  logic                  sync_rst_n,
   input  logic [NUM_DDR-1:0]    ready_q,
   input  logic [NUM_DDR-1:0]    scrb_done,
   input  logic [ADDR_W-1:0]     scrb_addr [NUM_DDR],
   input  logic                  awvalid,
   output logic                  awready,
   input  logic [31:0]           awaddr,
   input  logic                  wvalid,
   output logic                  wready,
   input  logic [DATA_W-1:0]     wdata,
   input  logic [DATA_W/8-1:0]   wstrb,
   output logic                  bvalid,
   input  logic                  bready,
   output logic [1:0]            bresp,
   input  logic                  arvalid,
   output logic                  arready,
   input  logic [31:0]           araddr,
   output logic                  rvalid,
   input  logic                  rready,
   output logic [DATA_W-1:0]     rdata,
   output logic [1:0]            rresp
);

   logic              wr_hs;
   logic              rd_hs;
   logic [DATA_W-1:0] scratch;
   logic [DATA_W-1:0] status_word;
   logic [DATA_W-1:0] rd_data;
   logic [1:0]        rd_resp;

   // --------------------------------------------------
   // write channel
   // --------------------------------------------------
   // address and data taken together, only with no response pending
   assign wr_hs   = awvalid && wvalid && !bvalid;
   assign awready = wr_hs;
   assign wready  = wr_hs;

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         bvalid  <= 1'b0;
         bresp   <= RESP_OKAY;
         scratch <= '0;
      end
      else if (wr_hs)
      begin
         bvalid <= 1'b1;
         // scratch is the only writable offset
         bresp  <= (awaddr == REG_SCRATCH) ? RESP_OKAY : RESP_SLVERR;
         if (awaddr == REG_SCRATCH)
         begin
            for (int b = 0; b < DATA_W / 8; b++)
            begin
               if (wstrb[b])
                  scratch[8*b +: 8] <= wdata[8*b +: 8];
            end
         end
      end
      else if (bready)
         bvalid <= 1'b0;
   end

   // --------------------------------------------------
   // read channel
   // --------------------------------------------------
   assign arready = arvalid && !rvalid;
   assign rd_hs   = arready;

   always_comb
   begin
      status_word                   = '0;
      status_word[NUM_DDR-1:0]      = scrb_done;
      status_word[NUM_DDR+3:4]      = ready_q;
   end

   // offset decode, unmapped reads give SLVERR with zero data
   always_comb
   begin
      rd_data = '0;
      rd_resp = RESP_SLVERR;
      if (araddr == REG_STATUS)
      begin
         rd_data = status_word;
         rd_resp = RESP_OKAY;
      end
      else if (araddr == REG_SCRATCH)
      begin
         rd_data = scratch;
         rd_resp = RESP_OKAY;
      end
      for (int i = 0; i < NUM_DDR; i++)
      begin
         if (araddr == REG_ADDR_BASE + 32'(8 * i))
         begin
            rd_data = scrb_addr[i][DATA_W-1:0];
            rd_resp = RESP_OKAY;
         end
         else if (araddr == REG_ADDR_BASE + 32'(8 * i + 4))
         begin
            rd_data = scrb_addr[i][ADDR_W-1:DATA_W];
            rd_resp = RESP_OKAY;
         end
      end
   end

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
         rvalid <= 1'b0;
      else if (rd_hs)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;
   end

   // read payload only loads on accept, held under rready stall
   always_ff @(posedge clk)
   begin
      if (rd_hs)
      begin
         rdata <= rd_data;
         rresp <= rd_resp;
      end
   end

endmodule

`default_nettype wire
